//--- flist.f
+incdir+include
design/rv_lite_pkg.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_lsu.sv
design/rv_control.sv
design/rv_lite_core.sv
dv/rv_lite_properties.sv
dv/rv_lite_checker.sv
dv/rv_lite_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module rv_lite_tb -o rv_lite_sim

./obj_dir/rv_lite_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log
then
	echo "simulation failed"
	exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log
then
	echo "simulation ended without a result"
	exit 1
fi

//--- dv/rv_lite_tb.sv
// Core testbench
`include "rv_lite_macros.svh"

module rv_lite_tb import rv_lite_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NT = 12;
	localparam int TIMEOUT_NS = NT * 64 * 2 * 100 * 2; // Twice the worst case over all tests
	localparam int SZ_B = 0;
	localparam int SZ_H = 1;
	localparam int SZ_W = 2;

	logic     clk;
	logic     rst;
	logic     core_stall;
	logic     reload;
	logic     done;
	word_t    bus_rdata;
	bus_req_t bus;

	word_t mem [256];
	word_t image [256];

	string names [NT];
	word_t prog [NT][16];
	bit    stall_tab [NT];
	addr_t exp_a [NT][8];
	word_t exp_d [NT][8];
	int    exp_s [NT][8];
	int    n_instr [NT];
	int    n_exp [NT];
	int    cur;

	rv_lite_core u_dut (
		.clk        (clk),
		.rst        (rst),
		.core_stall (core_stall),
		.bus_rdata  (bus_rdata),
		.bus        (bus)
	);

	rv_lite_checker u_chk (
		.clk        (clk),
		.rst        (rst),
		.core_stall (core_stall),
		.bus        (bus),
		.done       (done)
	);

	always #50 clk = ~clk;

	assign bus_rdata = mem[bus.addr[9:2]]; // Whole word, the core picks the bytes

	always @(posedge clk)
	begin
		if (reload)
			mem <= image;
		else if (!rst && bus.write_w)
			mem[bus.addr[9:2]] <= bus.wdata;
		else if (!rst && bus.write_h)
			mem[bus.addr[9:2]][{bus.addr[1], 4'b0000} +: 16] <= bus.wdata[15:0];
		else if (!rst && bus.write_b)
			mem[bus.addr[9:2]][{bus.addr[1:0], 3'b000} +: 8] <= bus.wdata[7:0];
	end

	// Background data, every byte depends on the word index
	function automatic word_t fill_word(input int i);
		return {i[7:0] ^ 8'hC3, i[7:0] ^ 8'h5A, i[7:0] ^ 8'h96, i[7:0] ^ 8'h0F};
	endfunction

	function automatic word_t load_ref(input addr_t a, input int f3);
		word_t w;
		w = fill_word(int'(a[9:2])) >> (8 * a[1:0]);
		case (f3)
		0: return {{24{w[7]}}, w[7:0]};
		1: return {{16{w[15]}}, w[15:0]};
		4: return {24'h0, w[7:0]};
		5: return {16'h0, w[15:0]};
		default: return w;
		endcase
	endfunction

	function automatic word_t enc_i(input int imm, input int rs1, input int f3, input int rd,
		input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic word_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
		input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic word_t enc_s(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t enc_b(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t enc_u(input int imm20, input int rd, input logic [6:0] op);
		return {imm20[19:0], rd[4:0], op};
	endfunction

	function automatic word_t enc_j(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic new_test(input string n, input bit st);
		cur++;
		names[cur]     = n;
		stall_tab[cur] = st;
		n_instr[cur]   = 0;
		n_exp[cur]     = 0;
	endtask

	task automatic add_instr(input word_t w);
		prog[cur][n_instr[cur]] = w;
		n_instr[cur]++;
	endtask

	task automatic add_store(input addr_t a, input word_t d, input int sz);
		exp_a[cur][n_exp[cur]] = a;
		exp_d[cur][n_exp[cur]] = d;
		exp_s[cur][n_exp[cur]] = sz;
		n_exp[cur]++;
	endtask

	// SW of one register to a fixed address, with its expected value
	task automatic store_word(input int r, input int off, input word_t d);
		add_instr(enc_s(off, r, 0, 2));
		add_store(addr_t'(off), d, SZ_W);
	endtask

	task automatic end_program();
		add_instr(enc_s(12'h3FC, 0, 0, 2));
	endtask

	task automatic add_alu_logic(input string n, input bit st);
		new_test(n, st);
		add_instr(enc_u(20'h12345, 1, OPC_LUI));
		add_instr(enc_i(12'h678, 1, 0, 1, OPC_OP_IMM));
		add_instr(enc_i(-5, 0, 0, 2, OPC_OP_IMM));
		add_instr(enc_r(0, 2, 1, 4, 3));
		add_instr(enc_i(12'h0F0, 1, 6, 4, OPC_OP_IMM));
		add_instr(enc_i(12'h0F0, 2, 7, 5, OPC_OP_IMM));
		add_instr(enc_i(12'h401, 2, 5, 6, OPC_OP_IMM)); // SRAI by 1
		add_instr(enc_i(28, 2, 5, 7, OPC_OP_IMM));
		add_instr(enc_i(4, 1, 1, 8, OPC_OP_IMM));
		store_word(3, 12'h200, 32'h12345678 ^ 32'hFFFFFFFB);
		store_word(4, 12'h204, 32'h123456F8);
		store_word(5, 12'h208, 32'h000000F0);
		store_word(6, 12'h20C, 32'hFFFFFFFD);
		store_word(7, 12'h210, 32'h0000000F);
		store_word(8, 12'h214, 32'h23456780);
		end_program();
	endtask

	task automatic add_branch_test(input string n, input bit take);
		int f3s [6] = '{0, 1, 4, 5, 6, 7};
		int ta [6]  = '{1, 1, 1, 2, 2, 1};
		int tb [6]  = '{1, 2, 2, 1, 1, 2};
		int na [6]  = '{1, 1, 2, 1, 1, 2};
		int nb [6]  = '{2, 1, 1, 2, 2, 1};
		new_test(n, 1'b0);
		add_instr(enc_i(-1, 0, 0, 1, OPC_OP_IMM)); // x1 = -1
		add_instr(enc_i(1, 0, 0, 2, OPC_OP_IMM));  // x2 = 1
		for (int k = 0; k < 6; k++)
		begin
			add_instr(take ? enc_b(8, tb[k], ta[k], f3s[k]) : enc_b(8, nb[k], na[k], f3s[k]));
			add_instr(enc_i(1 << k, 3, 0, 3, OPC_OP_IMM)); // Marker bit, skipped when taken
		end
		store_word(3, 12'h200, take ? 32'd0 : 32'd63);
		end_program();
	endtask

	// One load type at all four byte offsets of one word
	task automatic add_load_test(input string n, input int f3);
		new_test(n, 1'b0);
		for (int k = 0; k < 4; k++)
			add_instr(enc_i(12'h100 + k, 0, f3, k + 1, OPC_LOAD));
		for (int k = 0; k < 4; k++)
			store_word(k + 1, 12'h200 + 4 * k, load_ref(32'h100 + k, f3));
		end_program();
	endtask

	task automatic build_table();
		cur = -1;
		new_test("alu_arith", 1'b0);
		add_instr(enc_u(20'h12345, 1, OPC_LUI));
		add_instr(enc_i(12'h678, 1, 0, 1, OPC_OP_IMM));
		add_instr(enc_i(-5, 0, 0, 2, OPC_OP_IMM));
		add_instr(enc_r(0, 2, 1, 0, 3));
		add_instr(enc_r(7'h20, 2, 1, 0, 4));
		add_instr(enc_r(0, 1, 2, 2, 5)); // SLT -5 < x1
		add_instr(enc_r(0, 1, 2, 3, 6)); // SLTU wraps the other way
		store_word(3, 12'h200, 32'h12345678 - 32'd5);
		store_word(4, 12'h204, 32'h12345678 + 32'd5);
		store_word(5, 12'h208, 32'd1);
		store_word(6, 12'h20C, 32'd0);
		end_program();
		add_alu_logic("alu_logic_shift", 1'b0);
		add_branch_test("branch_taken", 1'b1);
		add_branch_test("branch_not_taken", 1'b0);
		new_test("jal_jalr", 1'b0);
		add_instr(enc_j(8, 1));
		add_instr(enc_i(1, 0, 0, 5, OPC_OP_IMM));
		add_instr(enc_i(12'h020, 0, 0, 6, OPC_OP_IMM));
		add_instr(enc_i(1, 6, 0, 2, OPC_JALR)); // Target 0x21 loses bit 0
		add_instr(enc_i(2, 0, 0, 5, OPC_OP_IMM));
		for (int k = 0; k < 3; k++)
			add_instr(enc_i(0, 0, 0, 0, OPC_OP_IMM));
		store_word(1, 12'h200, `RV_RESET_VECTOR + 32'h4);
		store_word(2, 12'h204, 32'h10);
		store_word(5, 12'h208, 32'h0);
		end_program();
		add_load_test("load_lb", 0);
		add_load_test("load_lbu", 4);
		add_load_test("load_lh", 1);
		add_load_test("load_lhu", 5);
		new_test("store_sub_word", 1'b0);
		add_instr(enc_u(20'hA1B2C, 1, OPC_LUI));
		add_instr(enc_i(12'h3D4, 1, 0, 1, OPC_OP_IMM));
		add_instr(enc_s(12'h101, 1, 0, 0));
		add_store(32'h101, 32'hA1B2C3D4, SZ_B);
		add_instr(enc_s(12'h102, 1, 0, 1));
		add_store(32'h102, 32'hA1B2C3D4, SZ_H);
		add_instr(enc_i(12'h101, 0, 4, 2, OPC_LOAD)); // Reads back the stored byte lane
		store_word(2, 12'h200, 32'h000000D4);
		end_program();
		new_test("auipc", 1'b0);
		add_instr(enc_i(0, 0, 0, 0, OPC_OP_IMM));
		add_instr(enc_u(20'h12345, 1, OPC_AUIPC));
		store_word(1, 12'h200, `RV_RESET_VECTOR + 32'h4 + 32'h12345000);
		end_program();
		add_alu_logic("alu_random_stall", 1'b1);
	endtask

	initial
	begin
		clk        = 1'b0;
		rst        = 1'b1;
		core_stall = 1'b0;
		reload     = 1'b0;
		void'($urandom(32'h16fd8de8));
		build_table();
		for (int t = 0; t < NT; t++)
		begin
			@(negedge clk);
			rst        = 1'b1;
			core_stall = 1'b0;
			for (int i = 0; i < 256; i++)
				image[i] = (i < 16) ? prog[t][i] : fill_word(i);
			reload = 1'b1;
			u_chk.start_test(names[t]);
			for (int k = 0; k < n_exp[t]; k++)
				u_chk.add_expect(exp_a[t][k], exp_d[t][k], exp_s[t][k]);
			repeat (2) @(negedge clk);
			reload = 1'b0;
			rst    = 1'b0;
			while (!done)
			begin
				core_stall = stall_tab[t] ? (($urandom % 3) == 0) : 1'b0;
				@(negedge clk);
			end
			core_stall = 1'b0;
			u_chk.end_test();
		end
		u_chk.report();
		if (u_chk.failed_tests == 0 && u_dut.u_props.fail_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- dv/rv_lite_checker.sv
// Store sequence checker
module rv_lite_checker import rv_lite_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     core_stall,
	input  bus_req_t bus,
	output logic     done
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam addr_t DONE_ADDR = 32'h0000_03FC;

	string test_name;
	addr_t exp_addr [$];
	word_t exp_data [$];
	int    exp_size [$];
	int    test_errors;
	int    passed_tests;
	int    failed_tests;
	int    act_size;
	logic  any_strobe;

	assign any_strobe = bus.write_w | bus.write_h | bus.write_b;
	assign act_size   = bus.write_w ? 2 : (bus.write_h ? 1 : 0); // 2 word, 1 half, 0 byte

	initial
	begin
		done         = 1'b0;
		passed_tests = 0;
		failed_tests = 0;
		test_errors  = 0;
	end

	task automatic start_test(input string name);
		test_name = name;
		exp_addr.delete();
		exp_data.delete();
		exp_size.delete();
		test_errors = 0;
		done        = 1'b0;
	endtask

	task automatic add_expect(input addr_t a, input word_t d, input int sz);
		exp_addr.push_back(a);
		exp_data.push_back(d);
		exp_size.push_back(sz);
	endtask

	always @(posedge clk)
	begin
		if (!rst && !done && any_strobe)
		begin
			if (core_stall)
			begin
				$display("%s: write strobe seen while core_stall is high", test_name);
				test_errors++;
			end
			if (!$onehot({bus.write_w, bus.write_h, bus.write_b}))
			begin
				$display("%s: more than one write strobe at once", test_name);
				test_errors++;
			end
			if (bus.addr == DONE_ADDR)
				done = 1'b1; // Program end marker
			else if (exp_addr.size() == 0)
			begin
				$display("extra store in %s: addr=%h data=%h size=%0d", test_name, bus.addr,
					bus.wdata, act_size);
				test_errors++;
			end
			else
			begin
				if (bus.addr != exp_addr[0] || bus.wdata != exp_data[0] ||
					act_size != exp_size[0])
				begin
					$display("mismatch %s: expected addr=%h data=%h size=%0d, actual addr=%h data=%h size=%0d",
						test_name, exp_addr[0], exp_data[0], exp_size[0], bus.addr,
						bus.wdata, act_size);
					test_errors++;
				end
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
				void'(exp_size.pop_front());
			end
		end
	end

	task automatic end_test();
		if (exp_addr.size() != 0)
		begin
			$display("missing store in %s: %0d expected stores never appeared", test_name,
				exp_addr.size());
			test_errors++;
		end
		if (test_errors == 0)
		begin
			$display("test %s: ok", test_name);
			passed_tests++;
		end
		else
		begin
			$display("test %s: failed with %0d errors", test_name, test_errors);
			failed_tests++;
		end
	endtask

	task automatic report();
		$display("tests run %0d, passed %0d, failed %0d", passed_tests + failed_tests,
			passed_tests, failed_tests);
	endtask

endmodule

//--- dv/rv_lite_properties.sv
// Bus strobe assertions
module rv_lite_properties import rv_lite_pkg::*; (
	input logic        clk,
	input logic        rst,
	input logic        core_stall,
	input bus_req_t    bus,
	input core_state_e state
);
	timeunit 1ns;
	timeprecision 1ps;

	logic any_strobe;
	int   fail_count = 0; // Failed assertion attempts

	assign any_strobe = bus.write_w | bus.write_h | bus.write_b;

	a_one_strobe: assert property (@(posedge clk) disable iff (rst)
		$onehot0({bus.write_w, bus.write_h, bus.write_b}))
		else
		begin
			fail_count++;
			$error("more than one write strobe high");
		end

	a_stall_quiet: assert property (@(posedge clk) disable iff (rst)
		core_stall |-> !any_strobe)
		else
		begin
			fail_count++;
			$error("write strobe high while core_stall is high");
		end

	a_fetch_quiet: assert property (@(posedge clk) disable iff (rst)
		(state == FETCH) |-> !any_strobe)
		else
		begin
			fail_count++;
			$error("write strobe high in FETCH");
		end

endmodule

bind rv_lite_core rv_lite_properties u_props (
	.clk        (clk),
	.rst        (rst),
	.core_stall (core_stall),
	.bus        (bus),
	.state      (u_control.state)
);

//--- design/rv_lite_core.sv
// RV32I single bus core
module rv_lite_core import rv_lite_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     core_stall,
	input  word_t    bus_rdata,
	output bus_req_t bus
);

	word_t instr;
	dec_t  dec;
	word_t rs1;
	word_t rs2;
	word_t alu_result;
	word_t load_result;
	word_t rd_data;
	word_t wdata;
	addr_t lsu_addr;
	addr_t bus_addr;
	logic  eq;
	logic  lt;
	logic  ltu;
	logic  exec;
	logic  rd_we;
	logic  write_w;
	logic  write_h;
	logic  write_b;

	rv_control u_control (
		.clk         (clk),
		.rst         (rst),
		.core_stall  (core_stall),
		.bus_rdata   (bus_rdata),
		.dec         (dec),
		.rs1         (rs1),
		.alu_result  (alu_result),
		.load_result (load_result),
		.eq          (eq),
		.lt          (lt),
		.ltu         (ltu),
		.lsu_addr    (lsu_addr),
		.instr       (instr),
		.exec        (exec),
		.bus_addr    (bus_addr),
		.rd_we       (rd_we),
		.rd_data     (rd_data)
	);

	rv_decoder u_decoder (
		.instr (instr),
		.dec   (dec)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.rst      (rst),
		.rs1_addr (dec.rs1),
		.rs2_addr (dec.rs2),
		.rd_addr  (dec.rd),
		.rd_we    (rd_we),
		.rd_data  (rd_data),
		.rs1      (rs1),
		.rs2      (rs2)
	);

	rv_alu u_alu (
		.dec        (dec),
		.rs1        (rs1),
		.rs2        (rs2),
		.alu_result (alu_result),
		.eq         (eq),
		.lt         (lt),
		.ltu        (ltu)
	);

	rv_lsu u_lsu (
		.dec         (dec),
		.exec        (exec),
		.rs1         (rs1),
		.rs2         (rs2),
		.bus_rdata   (bus_rdata),
		.lsu_addr    (lsu_addr),
		.wdata       (wdata),
		.write_w     (write_w),
		.write_h     (write_h),
		.write_b     (write_b),
		.load_result (load_result)
	);

	assign bus = '{addr: bus_addr, wdata: wdata, write_w: write_w,
		write_h: write_h, write_b: write_b};

endmodule

//--- design/rv_control.sv
// Fetch and execute sequencer
`include "rv_lite_macros.svh"

module rv_control import rv_lite_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  core_stall,
	input  word_t bus_rdata,
	input  dec_t  dec,
	input  word_t rs1,
	input  word_t alu_result,
	input  word_t load_result,
	input  logic  eq,
	input  logic  lt,
	input  logic  ltu,
	input  addr_t lsu_addr,
	output word_t instr,
	output logic  exec,
	output addr_t bus_addr,
	output logic  rd_we,
	output word_t rd_data
);

	core_state_e state;
	addr_t       pc;
	addr_t       pc_plus4;
	addr_t       next_pc;
	logic        mem_op;
	logic        taken;

	assign pc_plus4 = pc + 32'd4;
	assign exec     = (state == EXECUTE) && !core_stall; // Commit cycle
	assign mem_op   = (dec.op == OPC_LOAD) || (dec.op == OPC_STORE);

	// Bus carries the data address only while a load or store executes
	assign bus_addr = (state == EXECUTE && mem_op) ? lsu_addr : pc;

	always_comb
	begin
		case (dec.funct3)
		3'b000: taken = eq;   // BEQ
		3'b001: taken = !eq;  // BNE
		3'b100: taken = lt;   // BLT
		3'b101: taken = !lt;  // BGE
		3'b110: taken = ltu;  // BLTU
		3'b111: taken = !ltu; // BGEU
		default: taken = 1'b0;
		endcase
	end

	always_comb
	begin
		case (dec.op)
		OPC_JAL: next_pc = pc + dec.imm;
		OPC_JALR: next_pc = (rs1 + dec.imm) & ~32'd1;
		OPC_BRANCH: next_pc = taken ? pc + dec.imm : pc_plus4;
		default: next_pc = pc_plus4;
		endcase
	end

	// Write-back source
	always_comb
	begin
		rd_we   = 1'b0;
		rd_data = alu_result;
		case (dec.op)
		OPC_OP, OPC_OP_IMM: rd_we = exec;
		OPC_LOAD:
		begin
			rd_we   = exec;
			rd_data = load_result; // Read data is on the bus this cycle
		end
		OPC_LUI:
		begin
			rd_we   = exec;
			rd_data = dec.imm;
		end
		OPC_AUIPC:
		begin
			rd_we   = exec;
			rd_data = pc + dec.imm;
		end
		OPC_JAL, OPC_JALR:
		begin
			rd_we   = exec;
			rd_data = pc_plus4; // Link
		end
		default: rd_we = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= FETCH;
			pc    <= `RV_RESET_VECTOR;
		end
		else if (!core_stall)
		begin
			case (state)
			FETCH: state <= EXECUTE;
			EXECUTE:
			begin
				state <= FETCH;
				pc    <= next_pc;
			end
			default: state <= FETCH;
			endcase
		end
	end

	// Instruction register loads at the end of fetch
	always_ff @(posedge clk)
	begin
		if (!core_stall && state == FETCH)
			instr <= bus_rdata;
	end

endmodule

//--- design/rv_lsu.sv
// Load and store unit
module rv_lsu import rv_lite_pkg::*; (
	input  dec_t  dec,
	input  logic  exec,
	input  word_t rs1,
	input  word_t rs2,
	input  word_t bus_rdata,
	output addr_t lsu_addr,
	output word_t wdata,
	output logic  write_w,
	output logic  write_h,
	output logic  write_b,
	output word_t load_result
);

	word_t shifted;
	logic  store_now;

	// Decoder already picked the S or I immediate
	assign lsu_addr = rs1 + dec.imm;

	// Store data leaves unshifted, the strobe carries the size
	assign wdata     = rs2;
	assign store_now = exec && (dec.op == OPC_STORE);
	assign write_b   = store_now && (dec.funct3[1:0] == 2'b00);
	assign write_h   = store_now && (dec.funct3[1:0] == 2'b01);
	assign write_w   = store_now && (dec.funct3[1:0] == 2'b10);

	// Addressed byte moves down to bit 0
	assign shifted = bus_rdata >> {lsu_addr[1:0], 3'b000};

	always_comb
	begin
		case (dec.funct3)
		3'b000: load_result = {{24{shifted[7]}}, shifted[7:0]};   // LB
		3'b001: load_result = {{16{shifted[15]}}, shifted[15:0]}; // LH
		3'b100: load_result = {24'h000000, shifted[7:0]};         // LBU
		3'b101: load_result = {16'h0000, shifted[15:0]};          // LHU
		default: load_result = shifted;                           // LW
		endcase
	end

endmodule

//--- design/rv_regfile.sv
// Integer register file
`include "rv_lite_macros.svh"

module rv_regfile import rv_lite_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  reg_addr_t rs1_addr,
	input  reg_addr_t rs2_addr,
	input  reg_addr_t rd_addr,
	input  logic      rd_we,
	input  word_t     rd_data,
	output word_t     rs1,
	output word_t     rs2
);

	word_t regs [`RV_NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `RV_NUM_REGS; i++)
				regs[i] <= {`RV_XLEN{1'b0}};
		end
		else if (rd_we && rd_addr != '0) // x0 stays zero
			regs[rd_addr] <= rd_data;
	end

	assign rs1 = regs[rs1_addr]; // Asynchronous reads
	assign rs2 = regs[rs2_addr];

endmodule

//--- design/rv_alu.sv
// Integer ALU and comparator
module rv_alu import rv_lite_pkg::*; (
	input  dec_t  dec,
	input  word_t rs1,
	input  word_t rs2,
	output word_t alu_result,
	output logic  eq,
	output logic  lt,
	output logic  ltu
);

	word_t      op_b;
	logic [4:0] shamt;

	// Register form takes rs2, everything else the immediate
	assign op_b  = (dec.op == OPC_OP) ? rs2 : dec.imm;
	assign shamt = op_b[4:0];

	// Branch flags always compare the two registers
	assign eq  = (rs1 == rs2);
	assign lt  = ($signed(rs1) < $signed(rs2));
	assign ltu = (rs1 < rs2);

	always_comb
	begin
		case (dec.alu_op)
		ALU_ADD: alu_result = rs1 + op_b;
		ALU_SUB: alu_result = rs1 - op_b;
		ALU_SLL: alu_result = rs1 << shamt;
		ALU_SLT: alu_result = {31'b0, $signed(rs1) < $signed(op_b)};
		ALU_SLTU: alu_result = {31'b0, rs1 < op_b};
		ALU_XOR: alu_result = rs1 ^ op_b;
		ALU_SRL: alu_result = rs1 >> shamt;
		ALU_SRA: alu_result = word_t'($signed(rs1) >>> shamt); // Sign bit fills
		ALU_OR: alu_result = rs1 | op_b;
		ALU_AND: alu_result = rs1 & op_b;
		default: alu_result = rs1 + op_b;
		endcase
	end

endmodule

//--- design/rv_decoder.sv
// Instruction decoder
module rv_decoder import rv_lite_pkg::*; (
	input  word_t instr,
	output dec_t  dec
);

	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;
	logic  arith;

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign dec.rs1    = instr[19:15];
	assign dec.rs2    = instr[24:20];
	assign dec.rd     = instr[11:7];
	assign dec.funct3 = instr[14:12];

	always_comb
	begin
		case (instr[6:0])
		OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
		OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP:
			dec.op = opcode_e'(instr[6:0]);
		default: dec.op = OPC_ILLEGAL; // Runs as a no-op
		endcase
	end

	// Immediate format follows the opcode
	always_comb
	begin
		case (dec.op)
		OPC_STORE: dec.imm = imm_s;
		OPC_BRANCH: dec.imm = imm_b;
		OPC_LUI, OPC_AUIPC: dec.imm = imm_u;
		OPC_JAL: dec.imm = imm_j;
		default: dec.imm = imm_i; // OP_IMM, LOAD, JALR
		endcase
	end

	assign arith = (dec.op == OPC_OP) || (dec.op == OPC_OP_IMM);

	always_comb
	begin
		dec.alu_op = ALU_ADD; // Address adds and don't-cares
		if (arith)
		begin
			case (instr[14:12])
			3'b000: dec.alu_op = (dec.op == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
			3'b001: dec.alu_op = ALU_SLL;
			3'b010: dec.alu_op = ALU_SLT;
			3'b011: dec.alu_op = ALU_SLTU;
			3'b100: dec.alu_op = ALU_XOR;
			3'b101: dec.alu_op = instr[30] ? ALU_SRA : ALU_SRL; // Bit 30 also in SRAI
			3'b110: dec.alu_op = ALU_OR;
			default: dec.alu_op = ALU_AND;
			endcase
		end
	end

endmodule

//--- design/rv_lite_pkg.sv
// Core types and encodings
package rv_lite_pkg;

	typedef logic [31:0] word_t;     // Data word
	typedef logic [31:0] addr_t;     // Byte address on the bus
	typedef logic [4:0]  reg_addr_t; // Register index

	// Major opcodes, encoded as in instr[6:0]
	typedef enum logic [6:0] {
		OPC_ILLEGAL = 7'b0000000,
		OPC_LUI     = 7'b0110111,
		OPC_AUIPC   = 7'b0010111,
		OPC_JAL     = 7'b1101111,
		OPC_JALR    = 7'b1100111,
		OPC_BRANCH  = 7'b1100011,
		OPC_LOAD    = 7'b0000011,
		OPC_STORE   = 7'b0100011,
		OPC_OP_IMM  = 7'b0010011,
		OPC_OP      = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	typedef enum logic {
		FETCH,
		EXECUTE
	} core_state_e;

	// Decoded fields of the current instruction
	typedef struct packed {
		opcode_e   op;
		alu_op_e   alu_op;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t     imm;    // Already sign-extended for the format
		logic [2:0] funct3;
	} dec_t;

	// Single shared bus, fetch and data
	typedef struct packed {
		addr_t addr;
		word_t wdata;   // Unshifted rs2 on stores
		logic  write_w;
		logic  write_h;
		logic  write_b;
	} bus_req_t;

endpackage

//--- include/rv_lite_macros.svh
// Core configuration macros
`ifndef RV_LITE_MACROS_SVH
`define RV_LITE_MACROS_SVH

// First fetch address after reset
`define RV_RESET_VECTOR 32'h0000_0000

// Data path width
`define RV_XLEN 32

// Architectural integer registers, x0 included
`define RV_NUM_REGS 32

`endif
